// File: game_pkg.sv
package game_pkg;

    // Top level game flow
    typedef enum logic [1:0] {
        MENU  = 2'd0,
        GAME  = 2'd1,
        SCORE = 2'd2
    } game_state_t;

    // Which bird owns the slingshot
    typedef enum logic [2:0] {
        BIRD_0    = 3'd0,
        BIRD_1    = 3'd1,
        BIRD_2    = 3'd2,
        LAST_TURN = 3'd6,   // All birds used, waiting for the end screen
        NO_TURN   = 3'd7
    } turn_t;

    typedef enum logic [1:0] {
        WAIT_FOR_LOAD = 2'd0,
        LOADING       = 2'd1,   // Bird moving onto the sling
        WAIT_FOR_SHOT = 2'd2,   // Player aims here
        FLYING        = 2'd3
    } shot_state_t;

    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
        logic launch;
    } key_levels_t;

    typedef struct packed {
        logic              launch_press;  // New press seen at this frame
        logic signed [1:0] step_x;        // Right positive
        logic signed [1:0] step_y;        // Down positive
    } key_events_t;

    typedef struct packed {
        logic signed [7:0] dx;
        logic signed [7:0] dy;
    } aim_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        game_state_t game;
        turn_t       turn;
        shot_state_t shot;
        logic [9:0]  fade;   // Menu fade count
    } ctrl_t;

    // Sprite pixels of this colour are not drawn
    localparam rgb_t TRANSPARENT_KEY = '{r: 4'hF, g: 4'h6, b: 4'hF};
    localparam rgb_t SCORE_COLOUR    = '{r: 4'h2, g: 4'h2, b: 4'h2};

endpackage

// File: input_decoder.sv
`timescale 1ns/1ps

module input_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  game_pkg::key_levels_t keys,
    output game_pkg::key_events_t events
);
    import game_pkg::*;

    key_levels_t sync_meta;      // First synchroniser stage
    key_levels_t sync_keys;      // Safe to use from here on
    logic        launch_at_tick; // Launch level seen at the last frame tick

    // Opposite keys held together cancel out
    function automatic logic signed [1:0] unit_step(
        input logic pos,
        input logic neg
    );
        logic signed [1:0] step;
        case ({pos, neg})
            2'b10:   step = 2'sd1;
            2'b01:   step = -2'sd1;
            default: step = 2'sd0;
        endcase
        return step;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta <= '0;
            sync_keys <= '0;
        end else begin
            sync_meta <= keys;
            sync_keys <= sync_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            launch_at_tick <= 1'b0;
        end else if (frame_tick) begin
            launch_at_tick <= sync_keys.launch;
        end
    end

    always_comb begin
        events.launch_press = sync_keys.launch & ~launch_at_tick;
        events.step_x       = unit_step(sync_keys.right, sync_keys.left);
        events.step_y       = unit_step(sync_keys.down, sync_keys.up);
    end

endmodule

// File: game_sequencer.sv
`timescale 1ns/1ps

module game_sequencer #(
    parameter int LOAD_FRAMES   = 31,
    parameter int FLIGHT_FRAMES = 480,
    parameter int END_FRAMES    = 120,
    parameter int FADE_FRAMES   = 128
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  game_pkg::key_events_t events,
    output game_pkg::ctrl_t       ctrl
);
    import game_pkg::*;

    // Wide enough for any of the frame limits
    localparam int CNT_W = $clog2(LOAD_FRAMES + FLIGHT_FRAMES + END_FRAMES + 1);

    localparam logic [CNT_W-1:0] LOAD_LAST   = CNT_W'(LOAD_FRAMES);
    localparam logic [CNT_W-1:0] FLIGHT_LAST = CNT_W'(FLIGHT_FRAMES);
    localparam logic [CNT_W-1:0] END_LAST    = CNT_W'(END_FRAMES);
    localparam logic [9:0]       FADE_LAST   = 10'(FADE_FRAMES);

    game_state_t      game_state;
    game_state_t      game_next;
    turn_t            turn;
    turn_t            turn_next;
    shot_state_t      shot;
    shot_state_t      shot_next;
    logic [9:0]       fade_cnt;
    logic [9:0]       fade_next;
    logic [CNT_W-1:0] frame_cnt;
    logic [CNT_W-1:0] frame_next;

    logic flight_done;  // Shot leaves FLYING on this tick
    logic end_done;
    logic turn_active;

    assign flight_done = (shot == FLYING) && (frame_cnt >= FLIGHT_LAST);
    assign end_done    = (turn == LAST_TURN) && (frame_cnt >= END_LAST);
    assign turn_active = (game_state == GAME) && (turn != NO_TURN) && (turn != LAST_TURN);

    always_comb begin
        case (game_state)
            MENU:    game_next = (fade_cnt == FADE_LAST) ? GAME : MENU;
            GAME:    game_next = end_done ? SCORE : GAME;
            SCORE:   game_next = events.launch_press ? MENU : SCORE;
            default: game_next = MENU;
        endcase
    end

    // Fade starts on a press in the menu and runs to the limit
    always_comb begin
        if (game_state == MENU && events.launch_press && fade_cnt == '0) begin
            fade_next = 10'd1;
        end else if (fade_cnt == FADE_LAST) begin
            fade_next = '0;
        end else if (fade_cnt != '0) begin
            fade_next = fade_cnt + 10'd1;
        end else begin
            fade_next = fade_cnt;
        end
    end

    always_comb begin
        case (turn)
            NO_TURN:   turn_next = (game_state == GAME) ? BIRD_0 : NO_TURN;
            BIRD_0:    turn_next = flight_done ? BIRD_1 : BIRD_0;
            BIRD_1:    turn_next = flight_done ? BIRD_2 : BIRD_1;
            BIRD_2:    turn_next = flight_done ? LAST_TURN : BIRD_2;
            LAST_TURN: turn_next = end_done ? NO_TURN : LAST_TURN;
            default:   turn_next = NO_TURN;
        endcase
    end

    always_comb begin
        if (!turn_active) begin
            shot_next = WAIT_FOR_LOAD;  // No bird on the sling
        end else begin
            case (shot)
                WAIT_FOR_LOAD: shot_next = LOADING;
                LOADING:       shot_next = (frame_cnt >= LOAD_LAST) ? WAIT_FOR_SHOT : LOADING;
                WAIT_FOR_SHOT: shot_next = events.launch_press ? FLYING : WAIT_FOR_SHOT;
                FLYING:        shot_next = flight_done ? WAIT_FOR_LOAD : FLYING;
                default:       shot_next = WAIT_FOR_LOAD;
            endcase
        end
    end

    // Restart on any shot or turn change
    always_comb begin
        if (shot_next != shot || turn_next != turn) begin
            frame_next = '0;
        end else if (shot == LOADING || shot == FLYING || turn == LAST_TURN) begin
            frame_next = frame_cnt + 1'b1;
        end else begin
            frame_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= MENU;
            turn       <= NO_TURN;
            shot       <= WAIT_FOR_LOAD;
            fade_cnt   <= '0;
            frame_cnt  <= '0;
        end else if (frame_tick) begin
            game_state <= game_next;
            turn       <= turn_next;
            shot       <= shot_next;
            fade_cnt   <= fade_next;
            frame_cnt  <= frame_next;
        end
    end

    assign ctrl = '{game: game_state, turn: turn, shot: shot, fade: fade_cnt};

endmodule

// File: aim_control.sv
`timescale 1ns/1ps

module aim_control #(
    parameter int AIM_LIMIT = 63  // Must stay below 128
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  game_pkg::key_events_t events,
    input  game_pkg::shot_state_t shot,
    output game_pkg::aim_t        aim
);
    import game_pkg::*;

    // One bit of headroom so the sum cannot wrap
    logic signed [8:0] next_dx;
    logic signed [8:0] next_dy;
    logic              out_of_range;

    function automatic logic beyond_limit(input logic signed [8:0] v);
        return (v > AIM_LIMIT) || (v < -AIM_LIMIT);
    endfunction

    always_comb begin
        next_dx      = $signed(aim.dx) + $signed(events.step_x);
        next_dy      = $signed(aim.dy) + $signed(events.step_y);
        out_of_range = beyond_limit(next_dx) || beyond_limit(next_dy);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aim <= '0;
        end else if (frame_tick) begin
            if (shot != WAIT_FOR_SHOT) begin
                aim <= '0;  // Back to centre when not aiming
            end else if (!out_of_range) begin
                aim.dx <= next_dx[7:0];
                aim.dy <= next_dy[7:0];
            end
        end
    end

endmodule

// File: pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor (
    input  game_pkg::game_state_t game,
    input  logic [9:0]            fade,
    input  logic                  video_valid,
    input  game_pkg::rgb_t        menu_pixel,
    input  game_pkg::rgb_t        bg_pixel,
    input  game_pkg::rgb_t        sprite_pixel,
    input  game_pkg::rgb_t        sling_pixel,
    input  logic                  sprite_hit,
    input  logic                  sling_hit,
    output game_pkg::rgb_t        rgb
);
    import game_pkg::*;

    logic [4:0] dim;  // Fade step, one per 32 frames

    assign dim = fade[9:5];

    always_comb begin
        rgb = '0;
        if (video_valid) begin
            case (game)
                MENU: begin
                    rgb.r = menu_pixel.r >> dim;
                    rgb.g = menu_pixel.g >> dim;
                    rgb.b = menu_pixel.b >> dim;
                end
                GAME: begin
                    // Sprite over sling over background
                    if (sprite_hit && sprite_pixel != TRANSPARENT_KEY) begin
                        rgb = sprite_pixel;
                    end else if (sling_hit && sling_pixel != TRANSPARENT_KEY) begin
                        rgb = sling_pixel;
                    end else begin
                        rgb = bg_pixel;
                    end
                end
                SCORE:   rgb = SCORE_COLOUR;
                default: rgb = '0;
            endcase
        end
    end

endmodule

// File: slingshot_game_top.sv
`timescale 1ns/1ps

module slingshot_game_top #(
    parameter int LOAD_FRAMES   = 31,
    parameter int FLIGHT_FRAMES = 480,   // About eight seconds at 60 Hz
    parameter int END_FRAMES    = 120,
    parameter int FADE_FRAMES   = 128,
    parameter int AIM_LIMIT     = 63
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  game_pkg::key_levels_t keys,
    input  logic                  video_valid,
    input  game_pkg::rgb_t        menu_pixel,
    input  game_pkg::rgb_t        bg_pixel,
    input  logic                  sprite_hit,
    input  game_pkg::rgb_t        sprite_pixel,
    input  logic                  sling_hit,
    input  game_pkg::rgb_t        sling_pixel,
    output game_pkg::ctrl_t       ctrl,
    output game_pkg::aim_t        aim,
    output game_pkg::rgb_t        rgb
);
    import game_pkg::*;

    key_events_t events;

    input_decoder u_input_decoder (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .keys       (keys),
        .events     (events)
    );

    game_sequencer #(
        .LOAD_FRAMES   (LOAD_FRAMES),
        .FLIGHT_FRAMES (FLIGHT_FRAMES),
        .END_FRAMES    (END_FRAMES),
        .FADE_FRAMES   (FADE_FRAMES)
    ) u_game_sequencer (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .events     (events),
        .ctrl       (ctrl)
    );

    aim_control #(
        .AIM_LIMIT (AIM_LIMIT)
    ) u_aim_control (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .events     (events),
        .shot       (ctrl.shot),
        .aim        (aim)
    );

    pixel_compositor u_pixel_compositor (
        .game         (ctrl.game),
        .fade         (ctrl.fade),
        .video_valid  (video_valid),
        .menu_pixel   (menu_pixel),
        .bg_pixel     (bg_pixel),
        .sprite_pixel (sprite_pixel),
        .sling_pixel  (sling_pixel),
        .sprite_hit   (sprite_hit),
        .sling_hit    (sling_hit),
        .rgb          (rgb)
    );

endmodule

// File: slingshot_game_props.sv
`timescale 1ns/1ps

module slingshot_game_props #(
    parameter int FADE_FRAMES = 128,
    parameter int AIM_LIMIT   = 63
) (
    input logic            clk,
    input logic            rst,
    input logic            frame_tick,
    input game_pkg::ctrl_t ctrl,
    input game_pkg::aim_t  aim
);
    import game_pkg::*;

    // Menu is left only once the fade is complete
    property menu_held_until_faded;
        @(posedge clk) disable iff (rst)
        (frame_tick && ctrl.game == MENU && int'(ctrl.fade) != FADE_FRAMES)
            |=> (ctrl.game == MENU);
    endproperty

    property no_shot_outside_game;
        @(posedge clk) disable iff (rst)
        (ctrl.game != GAME) |-> (ctrl.shot == WAIT_FOR_LOAD);
    endproperty

    property aim_within_limit;
        @(posedge clk) disable iff (rst)
        ($signed(aim.dx) <= AIM_LIMIT) && ($signed(aim.dx) >= -AIM_LIMIT) &&
        ($signed(aim.dy) <= AIM_LIMIT) && ($signed(aim.dy) >= -AIM_LIMIT);
    endproperty

    // Aim clears on the first tick away from WAIT_FOR_SHOT
    property aim_zero_when_not_aiming;
        @(posedge clk) disable iff (rst)
        (frame_tick && ctrl.shot != WAIT_FOR_SHOT) |=> (aim == '0);
    endproperty

    a_menu_fade:  assert property (menu_held_until_faded) else $error("game left MENU early");
    a_shot_idle:  assert property (no_shot_outside_game) else $error("shot active outside GAME");
    a_aim_limit:  assert property (aim_within_limit) else $error("aim beyond limit");
    a_aim_clear:  assert property (aim_zero_when_not_aiming) else $error("aim not cleared");

endmodule

bind slingshot_game_top slingshot_game_props #(
    .FADE_FRAMES (FADE_FRAMES),
    .AIM_LIMIT   (AIM_LIMIT)
) u_slingshot_game_props (
    .clk        (clk),
    .rst        (rst),
    .frame_tick (frame_tick),
    .ctrl       (ctrl),
    .aim        (aim)
);

// File: tb_slingshot_game.sv
`timescale 1ns/1ps

module tb_slingshot_game;
    import game_pkg::*;

    localparam int LOAD_FRAMES   = 3;
    localparam int FLIGHT_FRAMES = 5;
    localparam int END_FRAMES    = 4;
    localparam int FADE_FRAMES   = 8;
    localparam int AIM_LIMIT     = 6;
    localparam int MAX_CYCLES    = 4000;   // About five times the expected run

    localparam key_levels_t K_NONE       = '0;
    localparam key_levels_t K_LAUNCH     = '{up: 0, left: 0, down: 0, right: 0, launch: 1};
    localparam key_levels_t K_RIGHT_DOWN = '{up: 0, left: 0, down: 1, right: 1, launch: 0};
    localparam key_levels_t K_RIGHT_UP   = '{up: 1, left: 0, down: 0, right: 1, launch: 0};
    localparam key_levels_t K_LEFT_UP    = '{up: 1, left: 1, down: 0, right: 0, launch: 0};
    localparam key_levels_t K_ALL_DIRS   = '{up: 1, left: 1, down: 1, right: 1, launch: 0};

    logic        clk;
    logic        rst;
    logic        frame_tick = 1'b0;
    key_levels_t keys;
    logic        video_valid;
    rgb_t        menu_pixel, bg_pixel, sprite_pixel, sling_pixel;
    logic        sprite_hit, sling_hit;
    ctrl_t       ctrl;
    aim_t        aim;
    rgb_t        rgb;

    // Reference model state
    game_state_t m_game;
    turn_t       m_turn;
    shot_state_t m_shot;
    int          m_fade, m_cnt, m_dx, m_dy;
    key_levels_t m_keys;
    logic        m_launch_prev;

    logic [31:0] lfsr = 32'h31d8;
    logic [2:0]  tick_phase;
    logic        ticked;
    logic        after_tick;
    int          cycles = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          n;
    int          last_ticks;
    turn_t       prev_turn;
    turn_t       turn_log[$];

    slingshot_game_top #(
        .LOAD_FRAMES   (LOAD_FRAMES),
        .FLIGHT_FRAMES (FLIGHT_FRAMES),
        .END_FRAMES    (END_FRAMES),
        .FADE_FRAMES   (FADE_FRAMES),
        .AIM_LIMIT     (AIM_LIMIT)
    ) u_slingshot_game_top (
        .clk (clk), .rst (rst), .frame_tick (frame_tick), .keys (keys),
        .video_valid (video_valid), .menu_pixel (menu_pixel), .bg_pixel (bg_pixel),
        .sprite_hit (sprite_hit), .sprite_pixel (sprite_pixel),
        .sling_hit (sling_hit), .sling_pixel (sling_pixel),
        .ctrl (ctrl), .aim (aim), .rgb (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One tick every 8 cycles
    always @(posedge clk) begin
        if (rst) begin
            tick_phase <= '0;
            frame_tick <= 1'b0;
        end else begin
            tick_phase <= tick_phase + 3'd1;
            frame_tick <= (tick_phase == 3'd7);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic int magnitude(input int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic rgb_t expected_rgb(input game_state_t g, input int fade);
        rgb_t c;
        c = '0;
        if (video_valid) begin
            if (g == MENU) begin
                c.r = menu_pixel.r >> (fade / 32);
                c.g = menu_pixel.g >> (fade / 32);
                c.b = menu_pixel.b >> (fade / 32);
            end else if (g == GAME) begin
                if (sprite_hit && sprite_pixel != TRANSPARENT_KEY) c = sprite_pixel;
                else if (sling_hit && sling_pixel != TRANSPARENT_KEY) c = sling_pixel;
                else c = bg_pixel;
            end else if (g == SCORE) begin
                c = SCORE_COLOUR;
            end
        end
        return c;
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("FAIL at %0t ns: %s", $time, msg);
            errors++;
            test_errors++;
        end
    endtask

    // Game, turn, shot and aim rules applied once per tick
    task automatic step_model();
        logic        press;
        int          sx, sy, nx, ny;
        logic        active;
        game_state_t g_n;
        turn_t       t_n;
        shot_state_t s_n;
        press  = m_keys.launch && !m_launch_prev;
        sx     = int'(m_keys.right) - int'(m_keys.left);
        sy     = int'(m_keys.down) - int'(m_keys.up);
        active = (m_game == GAME) && (m_turn != NO_TURN) && (m_turn != LAST_TURN);
        g_n = m_game;
        if (m_game == MENU && m_fade == FADE_FRAMES) g_n = GAME;
        if (m_game == GAME && m_turn == LAST_TURN && m_cnt == END_FRAMES) g_n = SCORE;
        if (m_game == SCORE && press) g_n = MENU;
        t_n = m_turn;
        case (m_turn)
            NO_TURN:   if (m_game == GAME) t_n = BIRD_0;
            BIRD_0:    if (m_shot == FLYING && m_cnt == FLIGHT_FRAMES) t_n = BIRD_1;
            BIRD_1:    if (m_shot == FLYING && m_cnt == FLIGHT_FRAMES) t_n = BIRD_2;
            BIRD_2:    if (m_shot == FLYING && m_cnt == FLIGHT_FRAMES) t_n = LAST_TURN;
            LAST_TURN: if (m_cnt == END_FRAMES) t_n = NO_TURN;
            default:   t_n = NO_TURN;
        endcase
        s_n = m_shot;
        if (!active) s_n = WAIT_FOR_LOAD;
        else if (m_shot == WAIT_FOR_LOAD) s_n = LOADING;
        else if (m_shot == LOADING && m_cnt == LOAD_FRAMES) s_n = WAIT_FOR_SHOT;
        else if (m_shot == WAIT_FOR_SHOT && press) s_n = FLYING;
        else if (m_shot == FLYING && m_cnt == FLIGHT_FRAMES) s_n = WAIT_FOR_LOAD;
        if (m_game == MENU && press && m_fade == 0) m_fade = 1;
        else if (m_fade == FADE_FRAMES) m_fade = 0;
        else if (m_fade != 0) m_fade++;
        if (s_n != m_shot || t_n != m_turn) m_cnt = 0;
        else if (m_shot == LOADING || m_shot == FLYING || m_turn == LAST_TURN) m_cnt++;
        else m_cnt = 0;
        if (m_shot == WAIT_FOR_SHOT) begin
            nx = m_dx + sx;
            ny = m_dy + sy;
            if (magnitude(nx) <= AIM_LIMIT && magnitude(ny) <= AIM_LIMIT) begin
                m_dx = nx;
                m_dy = ny;
            end
        end else begin
            m_dx = 0;
            m_dy = 0;
        end
        m_launch_prev = m_keys.launch;
        m_game = g_n;
        m_turn = t_n;
        m_shot = s_n;
    endtask

    task automatic cycle();
        @(posedge clk);
        ticked = frame_tick;
        if (ticked) step_model();
    endtask

    task automatic compare_state();
        expect_true(ctrl.game == m_game, "game state differs from model");
        expect_true(ctrl.turn == m_turn, "turn differs from model");
        expect_true(ctrl.shot == m_shot, "shot state differs from model");
        expect_true(int'(ctrl.fade) == m_fade, "fade count differs from model");
        expect_true(int'(aim.dx) == m_dx && int'(aim.dy) == m_dy, "aim differs from model");
    endtask

    // Run through the next tick, then compare away from the edge
    task automatic frame();
        do cycle(); while (!ticked);
        @(negedge clk);
        compare_state();
        after_tick = 1'b1;
    endtask

    // Keys change just after a tick so the synchroniser settles first
    task automatic set_keys(input key_levels_t k);
        if (!after_tick) frame();
        cycle();
        keys      <= k;
        m_keys     = k;
        after_tick = 1'b0;
    endtask

    // Mode 0 random, 1 opaque sprite, 2 keyed sprite over sling, 3 both keyed
    task automatic check_pixels(input logic valid, input int mode);
        rgb_t sp, lp;
        logic sh, lh;
        cycle();
        sp = 12'(random_bits(12));
        lp = 12'(random_bits(12));
        sh = 1'(random_bits(1));
        lh = 1'(random_bits(1));
        if (mode == 1) begin
            sh = 1'b1;
            if (sp == TRANSPARENT_KEY) sp = ~sp;
        end
        if (mode >= 2) begin
            sh = 1'b1;
            lh = 1'b1;
            sp = TRANSPARENT_KEY;
        end
        if (mode == 2 && lp == TRANSPARENT_KEY) lp = ~lp;
        if (mode == 3) lp = TRANSPARENT_KEY;
        video_valid  <= valid;
        menu_pixel   <= 12'(random_bits(12));
        bg_pixel     <= 12'(random_bits(12));
        sprite_pixel <= sp;
        sling_pixel  <= lp;
        sprite_hit   <= sh;
        sling_hit    <= lh;
        @(negedge clk);
        expect_true(rgb == expected_rgb(m_game, m_fade), "rgb differs from layer rules");
        after_tick = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %-14s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        rst = 1'b1;
        keys = '0;
        video_valid = 1'b0;
        menu_pixel = '0;
        bg_pixel = '0;
        sprite_pixel = '0;
        sling_pixel = '0;
        sprite_hit = 1'b0;
        sling_hit = 1'b0;
        m_game = MENU;
        m_turn = NO_TURN;
        m_shot = WAIT_FOR_LOAD;
        {m_fade, m_cnt, m_dx, m_dy} = '0;
        m_keys = '0;
        m_launch_prev = 1'b0;
        after_tick = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        @(negedge clk);
        compare_state();
        expect_true(ctrl == ctrl_t'{game: MENU, turn: NO_TURN, shot: WAIT_FOR_LOAD, fade: 10'd0},
                    "ctrl is not the reset value");
        check_pixels(1'b0, 0);
        expect_true(rgb == '0, "rgb is not black without valid video");
        check_pixels(1'b1, 0);
        expect_true(rgb == menu_pixel, "menu pixel not passed through at fade 0");
        finish_test("reset");

        // Menu to game
        set_keys(K_LAUNCH);
        frame();
        expect_true(ctrl.fade == 10'd1, "fade did not start on launch");
        set_keys(K_NONE);
        n = 0;
        while (m_game == MENU && n < 40) begin
            check_pixels(1'b1, 0);
            frame();
            n++;
        end
        expect_true(n == FADE_FRAMES && ctrl.game == GAME, "GAME not entered after fade");
        frame();
        expect_true(ctrl.turn == BIRD_0, "first bird not active after entering GAME");
        finish_test("menu_to_game");

        // Aiming
        n = 0;
        while (m_shot != WAIT_FOR_SHOT && n < 20) begin
            frame();
            n++;
        end
        set_keys(K_RIGHT_DOWN);
        repeat (AIM_LIMIT + 3) frame();
        expect_true(aim.dx == AIM_LIMIT && aim.dy == AIM_LIMIT, "aim did not stop at limit");
        set_keys(K_RIGHT_UP);
        frame();
        expect_true(aim.dx == AIM_LIMIT && aim.dy == AIM_LIMIT,
                    "aim moved while one offset was at the limit");
        set_keys(K_LEFT_UP);
        repeat (2 * AIM_LIMIT + 3) frame();
        expect_true(aim.dx == -AIM_LIMIT && aim.dy == -AIM_LIMIT,
                    "aim did not stop at the negative limit");
        set_keys(K_ALL_DIRS);
        repeat (2) frame();
        expect_true(aim.dx == -AIM_LIMIT && aim.dy == -AIM_LIMIT, "opposite keys moved aim");
        set_keys(K_LAUNCH);
        frame();
        set_keys(K_NONE);
        frame();
        expect_true(ctrl.shot == FLYING && aim == '0, "aim not cleared in flight");
        finish_test("aiming");

        // Layering while bird 0 flies
        repeat (8) check_pixels(1'b1, 0);
        check_pixels(1'b1, 1);
        check_pixels(1'b1, 2);
        check_pixels(1'b1, 3);
        check_pixels(1'b0, 1);
        finish_test("layering");

        // Remaining turns through to the score screen
        prev_turn  = ctrl.turn;
        last_ticks = 0;
        n = 0;
        while (m_game != SCORE && n < 300) begin
            if (m_shot == WAIT_FOR_SHOT && !m_keys.launch) set_keys(K_LAUNCH);
            else if (m_keys.launch) set_keys(K_NONE);
            frame();
            if (ctrl.turn == LAST_TURN) last_ticks++;
            if (ctrl.turn != prev_turn) turn_log.push_back(ctrl.turn);
            prev_turn = ctrl.turn;
            n++;
        end
        expect_true(ctrl.game == SCORE && ctrl.turn == NO_TURN, "score screen not reached");
        expect_true(turn_log.size() == 4, "wrong number of turn changes");
        if (turn_log.size() == 4) begin
            expect_true(turn_log[0] == BIRD_1 && turn_log[1] == BIRD_2 &&
                        turn_log[2] == LAST_TURN && turn_log[3] == NO_TURN,
                        "turns out of order");
        end
        expect_true(last_ticks == END_FRAMES + 1, "end delay has the wrong length");
        repeat (6) check_pixels(1'b1, 0);
        expect_true(rgb == SCORE_COLOUR, "score colour not shown");
        set_keys(K_LAUNCH);
        frame();
        expect_true(ctrl.game == MENU, "launch did not return to MENU");
        set_keys(K_NONE);
        frame();
        finish_test("turn_sequence");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
game_pkg.sv
input_decoder.sv
game_sequencer.sv
aim_control.sv
pixel_compositor.sv
slingshot_game_top.sv
slingshot_game_props.sv
tb_slingshot_game.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_slingshot_game
FILELIST   = compile.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then exit 1; fi
	@grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
